// File: Bender.yml
package:
  name: packet_q

sources:
  - verilog/packet_q_cfg_pkg.sv
  - verilog/packet_q_types_pkg.sv
  - verilog/packet_stream_intf.sv
  - verilog/sync_fifo.sv
  - verilog/buffer_allocator.sv
  - verilog/packet_buffer_mem.sv
  - verilog/packet_q_writer.sv
  - verilog/packet_q_reader.sv
  - verilog/packet_q_core.sv
  - target: test
    files:
      - tb/packet_q_tb_clock.sv
      - tb/packet_q_checker.sv
      - tb/packet_q_core_tb.sv

// File: build.f
verilog/packet_q_cfg_pkg.sv
verilog/packet_q_types_pkg.sv
verilog/packet_stream_intf.sv
verilog/sync_fifo.sv
verilog/buffer_allocator.sv
verilog/packet_buffer_mem.sv
verilog/packet_q_writer.sv
verilog/packet_q_reader.sv
verilog/packet_q_core.sv
tb/packet_q_tb_clock.sv
tb/packet_q_checker.sv
tb/packet_q_core_tb.sv

// File: tb/packet_q_checker.sv
module packet_q_checker
    import packet_q_cfg_pkg::*;
    import packet_q_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    out_valid,
    input  logic                    out_sop,
    input  logic                    out_eop,
    input  logic [MTY_WID-1:0]      out_mty,
    input  logic [DATA_WID-1:0]     out_data,
    input  meta_t                   out_meta,
    input  logic [DROP_CNT_WID-1:0] drop_count,
    input  logic                    drain_enable,
    input  logic                    drop_check,
    input  logic                    run_done,
    output int                      rx_count,
    output int                      value_errors,
    output int                      other_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                in_pkt;
    logic                unexpected;
    int                  byte_cnt;
    int                  base;
    int                  nvalid;
    logic [DATA_WID-1:0] exp_word;
    logic [DATA_WID-1:0] mask;
    // drain_enable as seen one and two clock edges back
    logic                drain_d1;
    logic                drain_d2;

    initial begin
        value_errors = 0;
        other_errors = 0;
    end

    task report_value(input string field, input logic [DATA_WID-1:0] expected,
                      input logic [DATA_WID-1:0] actual);
        $display("Error %s.%s expected %0h actual %0h",
                 packet_q_core_tb.test_name, field, expected, actual);
        value_errors++;
    endtask

    //====================================================================
    // Output packet assembly
    //====================================================================
    task check_word();
        int b;
        if (out_sop) begin
            if (in_pkt) begin
                $display("Start of packet at %0t while the previous packet had no end", $time);
                other_errors++;
            end
            // The pop that starts a packet comes two cycles before its sop
            if (drain_d2 !== 1'b1) begin
                $display("Output packet at %0t started while drain_enable was low", $time);
                other_errors++;
            end
            in_pkt     = 1'b1;
            byte_cnt   = 0;
            unexpected = (rx_count >= packet_q_core_tb.exp_count);
            if (unexpected) begin
                $display("Output packet at %0t arrived with no packet expected", $time);
                other_errors++;
            end else if (out_meta !== packet_q_core_tb.exp_meta[rx_count]) begin
                report_value("meta", packet_q_core_tb.exp_meta[rx_count], out_meta);
            end
        end
        if (!in_pkt) begin
            $display("Output word at %0t outside any packet", $time);
            other_errors++;
        end else begin
            // Valid bytes sit in the low end of the word
            nvalid = DATA_BYTE_WID - int'(out_mty);
            if (!unexpected) begin
                exp_word = '0;
                mask     = '0;
                base     = packet_q_core_tb.exp_off[rx_count];
                for (b = 0; b < nvalid; b++) begin
                    if (byte_cnt + b < packet_q_core_tb.exp_len[rx_count]) begin
                        exp_word[8*b +: 8] = packet_q_core_tb.exp_bytes[base + byte_cnt + b];
                        mask[8*b +: 8]     = 8'hff;
                    end
                end
                if ((out_data & mask) !== exp_word) begin
                    report_value("data", exp_word, out_data & mask);
                end
            end
            byte_cnt += nvalid;
            if (out_eop) begin
                if (!unexpected) begin
                    if (byte_cnt != packet_q_core_tb.exp_len[rx_count]) begin
                        report_value("length", packet_q_core_tb.exp_len[rx_count], byte_cnt);
                    end
                    rx_count++;
                end
                in_pkt = 1'b0;
            end
        end
    endtask

    task compare_drops();
        if (drop_count !== DROP_CNT_WID'(packet_q_core_tb.exp_drops)) begin
            report_value("drop_count", packet_q_core_tb.exp_drops, drop_count);
        end
    endtask

    task final_checks();
        compare_drops();
        if (in_pkt) begin
            $display("Run ended in the middle of an output packet");
            other_errors++;
        end
        if (rx_count < packet_q_core_tb.exp_count) begin
            $display("%0d expected packets never came out",
                     packet_q_core_tb.exp_count - rx_count);
            other_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            in_pkt     = 1'b0;
            unexpected = 1'b0;
            rx_count   = 0;
            drain_d1   = 1'b0;
            drain_d2   = 1'b0;
        end else begin
            if (out_valid === 1'b1) begin
                check_word();
            end
            if (drop_check) begin
                compare_drops();
            end
            if (run_done) begin
                final_checks();
            end
            drain_d2 = drain_d1;
            drain_d1 = drain_enable;
        end
    end

endmodule

// File: tb/packet_q_core_tb.sv
module packet_q_core_tb
    import packet_q_cfg_pkg::*;
    import packet_q_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 16;
    localparam int FILL_CYCLES   = NUM_BUFFERS + 2;
    localparam int N_SINGLE      = 12;
    localparam int N_STREAM      = 40;
    localparam int N_OVERSIZE    = 3;
    localparam int N_FLOOD       = NUM_BUFFERS + 3;
    localparam int TOTAL_PKTS    = N_SINGLE + N_STREAM + 2 * N_OVERSIZE + N_FLOOD + 1;
    localparam int MAX_PKT_WORDS = (400 + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
    // Longest packets, counted once in and once out, plus per packet overhead
    localparam int CYCLE_LIMIT   = TOTAL_PKTS * (2 * MAX_PKT_WORDS + 8)
                                   + RESET_CYCLES + FILL_CYCLES + 200;
    localparam int MAX_BYTES     = TOTAL_PKTS * BUFFER_BYTES;

    logic                    clk;
    logic                    reset;
    logic                    drain_enable;
    logic                    in_valid;
    logic                    in_sop;
    logic                    in_eop;
    logic [MTY_WID-1:0]      in_mty;
    logic [DATA_WID-1:0]     in_data;
    meta_t                   in_meta;
    logic                    out_valid;
    logic                    out_sop;
    logic                    out_eop;
    logic [MTY_WID-1:0]      out_mty;
    logic [DATA_WID-1:0]     out_data;
    meta_t                   out_meta;
    logic [DROP_CNT_WID-1:0] drop_count;

    logic                    drop_check;
    logic                    run_done;
    int                      rx_count;
    int                      value_errors;
    int                      other_errors;

    // Expected packets that the checker reads
    logic [7:0]              exp_bytes [MAX_BYTES];
    int                      exp_len [TOTAL_PKTS];
    int                      exp_off [TOTAL_PKTS];
    meta_t                   exp_meta [TOTAL_PKTS];
    int                      exp_count = 0;
    int                      exp_drops = 0;
    int                      byte_fill = 0;
    string                   test_name = "reset";

    int                      seed = 32'h4fa4b1a6;
    int                      cycle_count = 0;
    int                      i;

    packet_q_tb_clock #(.PERIOD_NS(40)) clock_i (.clk);

    packet_q_core packet_q_core_i (
        .clk, .reset, .drain_enable,
        .in_valid, .in_sop, .in_eop, .in_mty, .in_data, .in_meta,
        .out_valid, .out_sop, .out_eop, .out_mty, .out_data, .out_meta,
        .drop_count
    );

    packet_q_checker checker_i (
        .clk, .reset,
        .out_valid, .out_sop, .out_eop, .out_mty, .out_data, .out_meta,
        .drop_count, .drain_enable, .drop_check, .run_done,
        .rx_count, .value_errors, .other_errors
    );

    //====================================================================
    // Reference model
    //====================================================================
    // Kept only if it fits one buffer and a buffer is free at its start
    function automatic bit keep_packet(input int nbytes, input int free_bufs);
        if (nbytes > BUFFER_BYTES) begin
            return 1'b0;
        end
        return free_bufs > 0;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    //====================================================================
    // Stimulus
    //====================================================================
    task automatic drive_idle();
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_mty   = '0;
    endtask

    task automatic send_packet(input int nbytes);
        int                  nwords;
        int                  w;
        int                  b;
        bit                  keep;
        meta_t               meta;
        logic [DATA_WID-1:0] word;
        nwords = (nbytes + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
        meta   = meta_t'($random(seed));
        // Buffers in use are kept packets not yet seen leaving
        keep   = keep_packet(nbytes, NUM_BUFFERS - (exp_count - rx_count));
        if (keep) begin
            exp_len[exp_count]  = nbytes;
            exp_meta[exp_count] = meta;
            exp_off[exp_count]  = byte_fill;
        end else begin
            exp_drops++;
        end
        for (w = 0; w < nwords; w++) begin
            word = {$random(seed), $random(seed)};
            for (b = 0; b < DATA_BYTE_WID; b++) begin
                if (keep && w * DATA_BYTE_WID + b < nbytes) begin
                    exp_bytes[byte_fill + w * DATA_BYTE_WID + b] = word[8*b +: 8];
                end
            end
            in_valid = 1'b1;
            in_sop   = (w == 0);
            in_eop   = (w == nwords - 1);
            in_mty   = in_eop ? MTY_WID'(nwords * DATA_BYTE_WID - nbytes) : '0;
            in_data  = word;
            // Meta only counts on the sop word
            in_meta  = in_sop ? meta : ~meta;
            @(negedge clk);
        end
        if (keep) begin
            byte_fill += nbytes;
            exp_count++;
        end
    endtask

    task automatic wait_drained();
        while (rx_count < exp_count) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic check_drops(input string name);
        test_name  = name;
        drop_check = 1'b1;
        @(negedge clk);
        drop_check = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        reset        = 1'b1;
        drain_enable = 1'b1;
        in_data      = '0;
        in_meta      = '0;
        drop_check   = 1'b0;
        run_done     = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // Free list fills one pointer per cycle
        repeat (FILL_CYCLES) @(negedge clk);

        // Quiet output and zero drops
        test_name = "after_reset";
        repeat (20) @(negedge clk);
        check_drops("after_reset");

        // One packet at a time with the two length limits first
        test_name = "single_packets";
        for (i = 0; i < N_SINGLE; i++) begin
            if (i == 0) begin
                send_packet(1);
            end else if (i == 1) begin
                send_packet(BUFFER_BYTES);
            end else begin
                send_packet(rand_range(1, BUFFER_BYTES));
            end
            drive_idle();
            wait_drained();
        end

        // Long enough that the drain keeps up with the input
        test_name = "back_to_back";
        for (i = 0; i < N_STREAM; i++) begin
            send_packet(rand_range(64, BUFFER_BYTES));
        end
        drive_idle();
        wait_drained();

        test_name = "oversize_drop";
        for (i = 0; i < N_OVERSIZE; i++) begin
            send_packet(rand_range(BUFFER_BYTES + 1, 400));
            send_packet(rand_range(1, BUFFER_BYTES));
        end
        drive_idle();
        wait_drained();
        check_drops("oversize_drop");

        // Fill every buffer while the drain is held off
        test_name    = "buffer_exhaustion";
        drain_enable = 1'b0;
        for (i = 0; i < N_FLOOD; i++) begin
            send_packet(rand_range(1, BUFFER_BYTES));
        end
        drive_idle();
        repeat (8) @(negedge clk);
        check_drops("buffer_exhaustion");
        drain_enable = 1'b1;
        wait_drained();
        send_packet(rand_range(1, BUFFER_BYTES));
        drive_idle();
        wait_drained();
        check_drops("buffer_exhaustion");

        test_name = "end_of_run";
        run_done  = 1'b1;
        @(negedge clk);
        run_done = 1'b0;
        $display("Closing: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb/packet_q_tb_clock.sv
module packet_q_tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: verilog/buffer_allocator.sv
module buffer_allocator
    import packet_q_cfg_pkg::*;
    import packet_q_types_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic alloc,
    input  logic free_a,
    input  ptr_t free_a_ptr,
    input  logic free_b,
    input  ptr_t free_b_ptr,
    output logic alloc_valid,
    output ptr_t alloc_ptr
);
    logic init_busy;
    ptr_t init_ptr;
    logic hold_valid;
    ptr_t hold_ptr;
    logic push;
    ptr_t push_ptr;
    logic empty;

    // At most one push per cycle into the free list
    assign push = init_busy || hold_valid || free_a || free_b;

    always_comb begin
        if (init_busy) begin
            push_ptr = init_ptr;
        end else if (hold_valid) begin
            push_ptr = hold_ptr;
        end else if (free_a) begin
            push_ptr = free_a_ptr;
        end else begin
            push_ptr = free_b_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            init_busy  <= 1'b1;
            init_ptr   <= '0;
            hold_valid <= 1'b0;
        end else begin
            if (init_busy) begin
                init_ptr <= init_ptr + 1'b1;
                if (init_ptr == PTR_WID'(NUM_BUFFERS - 1)) begin
                    init_busy <= 1'b0;
                end
            end
            // Second strobe of a cycle waits one cycle here
            if (hold_valid) begin
                hold_valid <= free_a || free_b;
            end else begin
                hold_valid <= free_a && free_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        hold_ptr <= (hold_valid && free_a) ? free_a_ptr : free_b_ptr;
    end

    sync_fifo #(
        .T     ( ptr_t ),
        .DEPTH ( NUM_BUFFERS )
    ) free_fifo_i (
        .clk,
        .reset,
        .wr_en   ( push ),
        .wr_data ( push_ptr ),
        .rd_en   ( alloc ),
        .rd_data ( alloc_ptr ),
        .empty,
        .full    ( )
    );

    assign alloc_valid = !empty;

    a_alloc_valid: assert property (@(posedge clk) disable iff (reset) alloc |-> alloc_valid);

endmodule

// File: verilog/packet_buffer_mem.sv
module packet_buffer_mem
    import packet_q_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [DATA_WID-1:0] wr_data,
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data
);
    logic [DATA_WID-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/packet_q_cfg_pkg.sv
package packet_q_cfg_pkg;

    //====================================================================
    // Stream word
    //====================================================================
    localparam int DATA_BYTE_WID = 8;
    localparam int DATA_WID      = DATA_BYTE_WID * 8;
    localparam int MTY_WID       = $clog2(DATA_BYTE_WID);
    localparam int META_WID      = 32;

    //====================================================================
    // Buffers and memory
    //====================================================================
    // One packet per buffer
    localparam int BUFFER_WORDS  = 32;
    localparam int BUFFER_BYTES  = BUFFER_WORDS * DATA_BYTE_WID;
    localparam int NUM_BUFFERS   = 16;
    localparam int PTR_WID       = $clog2(NUM_BUFFERS);
    localparam int WORD_IDX_WID  = $clog2(BUFFER_WORDS);

    localparam int MEM_DEPTH     = NUM_BUFFERS * BUFFER_WORDS;
    localparam int ADDR_WID      = $clog2(MEM_DEPTH);

    // Byte length must reach BUFFER_BYTES itself
    localparam int LEN_WID       = $clog2(BUFFER_BYTES + 1);

    localparam int DROP_CNT_WID  = 16;

endpackage

// File: verilog/packet_q_core.sv
module packet_q_core
    import packet_q_cfg_pkg::*;
    import packet_q_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    drain_enable,
    input  logic                    in_valid,
    input  logic                    in_sop,
    input  logic                    in_eop,
    input  logic [MTY_WID-1:0]      in_mty,
    input  logic [DATA_WID-1:0]     in_data,
    input  meta_t                   in_meta,
    output logic                    out_valid,
    output logic                    out_sop,
    output logic                    out_eop,
    output logic [MTY_WID-1:0]      out_mty,
    output logic [DATA_WID-1:0]     out_data,
    output meta_t                   out_meta,
    output logic [DROP_CNT_WID-1:0] drop_count
);
    packet_stream_intf in_if ();
    packet_stream_intf out_if ();

    logic                alloc;
    logic                alloc_valid;
    ptr_t                alloc_ptr;
    logic                wr_free;
    ptr_t                wr_free_ptr;
    logic                rd_free;
    ptr_t                rd_free_ptr;

    logic                mem_wr_en;
    logic [ADDR_WID-1:0] mem_wr_addr;
    logic [DATA_WID-1:0] mem_wr_data;
    logic                mem_rd_en;
    logic [ADDR_WID-1:0] mem_rd_addr;
    logic [DATA_WID-1:0] mem_rd_data;

    logic                desc_wr_en;
    desc_t               desc_wr_data;
    logic                desc_rd_en;
    desc_t               desc_rd_data;
    logic                desc_empty;

    //====================================================================
    // Port wrapping
    //====================================================================
    assign in_if.valid = in_valid;
    assign in_if.sop   = in_sop;
    assign in_if.eop   = in_eop;
    assign in_if.mty   = in_mty;
    assign in_if.data  = in_data;
    assign in_if.meta  = in_meta;

    assign out_valid = out_if.valid;
    assign out_sop   = out_if.sop;
    assign out_eop   = out_if.eop;
    assign out_mty   = out_if.mty;
    assign out_data  = out_if.data;
    assign out_meta  = out_if.meta;

    //====================================================================
    // Blocks
    //====================================================================
    packet_q_writer packet_q_writer_i (
        .clk, .reset,
        .in           ( in_if ),
        .alloc_valid, .alloc_ptr, .alloc,
        .free         ( wr_free ),
        .free_ptr     ( wr_free_ptr ),
        .mem_wr_en, .mem_wr_addr, .mem_wr_data,
        .desc_wr_en, .desc_wr_data,
        .drop_count
    );

    // Every entry owns a buffer, so NUM_BUFFERS entries always suffice
    sync_fifo #(
        .T     ( desc_t ),
        .DEPTH ( NUM_BUFFERS )
    ) desc_fifo_i (
        .clk, .reset,
        .wr_en   ( desc_wr_en ),
        .wr_data ( desc_wr_data ),
        .rd_en   ( desc_rd_en ),
        .rd_data ( desc_rd_data ),
        .empty   ( desc_empty ),
        .full    ( )
    );

    buffer_allocator buffer_allocator_i (
        .clk, .reset, .alloc,
        .free_a     ( wr_free ),
        .free_a_ptr ( wr_free_ptr ),
        .free_b     ( rd_free ),
        .free_b_ptr ( rd_free_ptr ),
        .alloc_valid, .alloc_ptr
    );

    packet_buffer_mem packet_buffer_mem_i (
        .clk,
        .wr_en   ( mem_wr_en ),
        .wr_addr ( mem_wr_addr ),
        .wr_data ( mem_wr_data ),
        .rd_en   ( mem_rd_en ),
        .rd_addr ( mem_rd_addr ),
        .rd_data ( mem_rd_data )
    );

    packet_q_reader packet_q_reader_i (
        .clk, .reset, .drain_enable,
        .desc_empty, .desc_rd_data, .mem_rd_data,
        .desc_rd_en, .mem_rd_en, .mem_rd_addr,
        .free     ( rd_free ),
        .free_ptr ( rd_free_ptr ),
        .out      ( out_if )
    );

endmodule

// File: verilog/packet_q_reader.sv
module packet_q_reader
    import packet_q_cfg_pkg::*;
    import packet_q_types_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                drain_enable,
    input  logic                desc_empty,
    input  desc_t               desc_rd_data,
    input  logic [DATA_WID-1:0] mem_rd_data,
    output logic                desc_rd_en,
    output logic                mem_rd_en,
    output logic [ADDR_WID-1:0] mem_rd_addr,
    output logic                free,
    output ptr_t                free_ptr,
    packet_stream_intf.source   out
);
    typedef enum logic {
        IDLE,
        READ
    } state_t;

    state_t                  state;
    desc_t                   cur_desc;
    logic [WORD_IDX_WID-1:0] rd_idx;
    logic [WORD_IDX_WID-1:0] last_idx;
    logic [MTY_WID-1:0]      last_mty;
    logic                    last_read;

    // drain_enable only gates the start of a packet
    assign desc_rd_en = (state == IDLE) && drain_enable && !desc_empty;

    // Word count is the byte length rounded up
    assign last_idx  = WORD_IDX_WID'((cur_desc.len - 1'b1) / DATA_BYTE_WID);
    assign last_mty  = MTY_WID'(DATA_BYTE_WID - (cur_desc.len % DATA_BYTE_WID));
    assign last_read = (state == READ) && (rd_idx == last_idx);

    assign mem_rd_en   = (state == READ);
    assign mem_rd_addr = {cur_desc.ptr, rd_idx};

    //====================================================================
    // Read FSM
    //====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            rd_idx    <= '0;
            out.valid <= 1'b0;
            free      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    rd_idx <= '0;
                    if (desc_rd_en) begin
                        state <= READ;
                    end
                end
                READ: begin
                    rd_idx <= rd_idx + 1'b1;
                    if (last_read) begin
                        state <= IDLE;
                    end
                end
            endcase
            out.valid <= mem_rd_en;
            free      <= last_read;
        end
    end

    // Sideband delayed one cycle to line up with RAM data
    always_ff @(posedge clk) begin
        if (desc_rd_en) begin
            cur_desc <= desc_rd_data;
        end
        out.sop  <= (rd_idx == '0);
        out.eop  <= last_read;
        out.mty  <= last_read ? last_mty : '0;
        out.meta <= cur_desc.meta;
        free_ptr <= cur_desc.ptr;
    end

    assign out.data = mem_rd_data;

endmodule

// File: verilog/packet_q_types_pkg.sv
package packet_q_types_pkg;
    import packet_q_cfg_pkg::*;

    // Buffer index into the shared memory
    typedef logic [PTR_WID-1:0]  ptr_t;

    // Packet length in bytes
    typedef logic [LEN_WID-1:0]  len_t;

    typedef logic [META_WID-1:0] meta_t;

    // One entry per stored packet
    typedef struct packed {
        ptr_t  ptr;
        len_t  len;
        meta_t meta;
    } desc_t;

endpackage

// File: verilog/packet_q_writer.sv
module packet_q_writer
    import packet_q_cfg_pkg::*;
    import packet_q_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    packet_stream_intf.sink         in,
    input  logic                    alloc_valid,
    input  ptr_t                    alloc_ptr,
    output logic                    alloc,
    output logic                    free,
    output ptr_t                    free_ptr,
    output logic                    mem_wr_en,
    output logic [ADDR_WID-1:0]     mem_wr_addr,
    output logic [DATA_WID-1:0]     mem_wr_data,
    output logic                    desc_wr_en,
    output desc_t                   desc_wr_data,
    output logic [DROP_CNT_WID-1:0] drop_count
);
    logic                    in_pkt;
    logic                    keep;
    logic                    oversize;
    logic [WORD_IDX_WID-1:0] word_idx;
    ptr_t                    cur_ptr;
    meta_t                   cur_meta;

    logic                    start_ok;
    logic                    store;
    logic                    drop;
    ptr_t                    wr_ptr;
    logic [WORD_IDX_WID-1:0] wr_idx;

    //====================================================================
    // Word path
    //====================================================================
    assign start_ok = in.valid && in.sop && alloc_valid;
    assign alloc    = start_ok;

    // sop word goes to the fresh buffer, later words to the latched one
    assign wr_ptr = in.sop ? alloc_ptr : cur_ptr;
    assign wr_idx = in.sop ? '0 : word_idx;
    assign store  = start_ok || (in.valid && !in.sop && in_pkt && keep && !oversize);

    assign mem_wr_en   = store;
    assign mem_wr_addr = {wr_ptr, wr_idx};
    assign mem_wr_data = in.data;

    // Descriptor goes out with the eop word
    assign desc_wr_en        = store && in.eop;
    assign desc_wr_data.ptr  = wr_ptr;
    assign desc_wr_data.len  = len_t'(wr_idx) * len_t'(DATA_BYTE_WID)
                               + len_t'(DATA_BYTE_WID) - len_t'(in.mty);
    assign desc_wr_data.meta = in.sop ? in.meta : cur_meta;

    // Oversize packet returns its buffer at eop
    assign free     = in.valid && in.eop && !in.sop && in_pkt && keep && oversize;
    assign free_ptr = cur_ptr;

    assign drop = (in.valid && in.sop && !alloc_valid) || free;

    //====================================================================
    // Packet state
    //====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt     <= 1'b0;
            keep       <= 1'b0;
            oversize   <= 1'b0;
            word_idx   <= '0;
            drop_count <= '0;
        end else begin
            if (in.valid) begin
                in_pkt <= !in.eop;
            end
            if (in.valid && in.sop) begin
                keep <= alloc_valid;
            end
            if (store) begin
                word_idx <= wr_idx + 1'b1;
            end
            // Buffer full and still no eop
            if (in.valid && in.sop) begin
                oversize <= 1'b0;
            end else if (store && !in.eop && word_idx == WORD_IDX_WID'(BUFFER_WORDS - 1)) begin
                oversize <= 1'b1;
            end
            if (drop) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            cur_ptr  <= alloc_ptr;
            cur_meta <= in.meta;
        end
    end

    a_sop_outside: assert property (@(posedge clk) disable iff (reset)
        in.valid && in.sop |-> !in_pkt);
    a_eop_inside: assert property (@(posedge clk) disable iff (reset)
        in.valid && in.eop && !in.sop |-> in_pkt);

endmodule

// File: verilog/packet_stream_intf.sv
interface packet_stream_intf import packet_q_cfg_pkg::*, packet_q_types_pkg::*; ();

    logic                valid;
    logic                sop;
    logic                eop;
    // Unused high bytes of the eop word
    logic [MTY_WID-1:0]  mty;
    logic [DATA_WID-1:0] data;
    // Only meaningful on the sop word
    meta_t               meta;

    modport source (
        output valid,
        output sop,
        output eop,
        output mty,
        output data,
        output meta
    );

    modport sink (
        input valid,
        input sop,
        input eop,
        input mty,
        input data,
        input meta
    );

endinterface

// File: verilog/sync_fifo.sv
module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic wr_en,
    input  T     wr_data,
    input  logic rd_en,
    output T     rd_data,
    output logic empty,
    output logic full
);
    localparam int IDX_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    T                   slots [DEPTH];
    logic [IDX_WID-1:0] wr_idx;
    logic [IDX_WID-1:0] rd_idx;
    logic [CNT_WID-1:0] count;

    function automatic logic [IDX_WID-1:0] next_idx(input logic [IDX_WID-1:0] idx);
        return (idx == IDX_WID'(DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            slots[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_idx <= next_idx(wr_idx);
            end
            if (rd_en) begin
                rd_idx <= next_idx(rd_idx);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead, head entry always on the output
    assign rd_data = slots[rd_idx];
    assign empty   = (count == '0);
    assign full    = (count == CNT_WID'(DEPTH));

    a_no_write_full: assert property (@(posedge clk) disable iff (reset) wr_en |-> !full);
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty);

endmodule
